// ==== source/can_rx_pkg.sv ====
// CAN receive buffer definitions
`default_nettype none

package can_rx_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////////////////////////////////////////

  // Bytes held in the data memory
  localparam int DATA_DEPTH = 64;
  // Frame records held in the length and overrun memories
  localparam int INFO_DEPTH = 64;

  // Pointer into either memory
  localparam int PTR_W = 6;
  // Occupancy count, one bit wider than a pointer so that full fits
  localparam int CNT_W = 7;
  // Stored frame length
  localparam int LEN_W = 4;

  // Host window base, per addressing mode
  localparam logic [PTR_W-1:0] EXT_WINDOW_BASE = 6'd16;
  localparam logic [PTR_W-1:0] STD_WINDOW_BASE = 6'd20;

  ////////////////////////////////////////////////////////////////////////////
  // Records passed between blocks
  ////////////////////////////////////////////////////////////////////////////

  // One accepted byte, already checked against data fullness
  typedef struct packed {
    logic       valid;
    logic [7:0] data;
  } byte_wr_t;

  // Frame close, raised for one cycle when the strobe has dropped
  typedef struct packed {
    logic             valid;
    logic [LEN_W-1:0] len;
    logic             overrun;
  } frame_info_t;

  // Oldest queued frame as seen by the host side
  typedef struct packed {
    logic [LEN_W-1:0] len;
    logic             overrun;
    logic             present;
  } head_info_t;

endpackage

`default_nettype wire

// ==== source/can_rx_frame_writer.sv ====
// CAN receive frame writer
`timescale 1ns/1ps
`default_nettype none

module can_rx_frame_writer (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic                                 reset_mode_i,
  input  logic                                 wr_i,
  input  logic [7:0]                           data_i,
  input  logic                                 data_full_i,
  output can_rx_pkg::byte_wr_t                 byte_wr_o,
  output can_rx_pkg::frame_info_t              frame_close_o
);

  // Strobe seen at the previous edge
  logic                         wr_q;
  // Bytes of the current frame that made it into memory
  logic [can_rx_pkg::LEN_W-1:0] len_cnt;
  // Set once any byte of the current frame was refused
  logic                         overrun_q;

  logic                         byte_take;
  logic                         byte_lost;
  logic                         frame_end;

  ////////////////////////////////////////////////////////////////////////////
  // Byte path
  ////////////////////////////////////////////////////////////////////////////

  // Only this block looks at data fullness
  assign byte_take = wr_i & ~data_full_i & ~reset_mode_i;
  assign byte_lost = wr_i & data_full_i;

  // Strobe falling edge closes the frame
  assign frame_end = wr_q & ~wr_i;

  assign byte_wr_o.valid = byte_take;
  assign byte_wr_o.data  = data_i;

  ////////////////////////////////////////////////////////////////////////////
  // Frame tracking
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      wr_q      <= 1'b0;
      len_cnt   <= '0;
      overrun_q <= 1'b0;
    end
    else if (reset_mode_i)
    begin
      wr_q      <= 1'b0;
      len_cnt   <= '0;
      overrun_q <= 1'b0;
    end
    else
    begin
      wr_q <= wr_i;
      // Start over for the next frame
      if (frame_end)
      begin
        len_cnt   <= '0;
        overrun_q <= 1'b0;
      end
      else
      begin
        if (byte_take)
          len_cnt <= len_cnt + 1'b1;
        // A refusal on the last strobe cycle is latched here too
        if (byte_lost)
          overrun_q <= 1'b1;
      end
    end
  end

  // Close record valid for one cycle after the falling edge
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      frame_close_o <= '0;
    else if (reset_mode_i)
      frame_close_o <= '0;
    else
    begin
      frame_close_o.valid   <= frame_end;
      frame_close_o.len     <= len_cnt;
      frame_close_o.overrun <= overrun_q;
    end
  end

  // A frame never holds more bytes than its length field can count
  a_len_no_wrap: assert property (
    @(posedge clk) disable iff (rst) byte_take |-> (len_cnt != {can_rx_pkg::LEN_W{1'b1}}));

endmodule

`default_nettype wire

// ==== source/can_rx_buffer_store.sv ====
// CAN receive buffer store
`timescale 1ns/1ps
`default_nettype none

module can_rx_buffer_store (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic                                 reset_mode_i,
  input  can_rx_pkg::byte_wr_t                 byte_wr_i,
  input  can_rx_pkg::frame_info_t              frame_close_i,
  input  logic                                 release_take_i,
  input  logic [can_rx_pkg::PTR_W-1:0]         rd_addr_i,
  output logic [7:0]                           rd_data_o,
  output logic [can_rx_pkg::PTR_W-1:0]         rd_ptr_o,
  output logic                                 data_full_o,
  output can_rx_pkg::head_info_t               head_o,
  output logic [can_rx_pkg::CNT_W-1:0]         info_cnt_o
);

  ////////////////////////////////////////////////////////////////////////////
  // Storage
  ////////////////////////////////////////////////////////////////////////////

  // Received bytes, frames packed back to back
  logic [7:0]                   data_mem [can_rx_pkg::DATA_DEPTH];
  // Per-frame stored length and overrun flag
  logic [can_rx_pkg::LEN_W-1:0] len_mem  [can_rx_pkg::INFO_DEPTH];
  logic                         ovr_mem  [can_rx_pkg::INFO_DEPTH];

  // Byte side pointers and fill level
  logic [can_rx_pkg::PTR_W-1:0] wr_ptr;
  logic [can_rx_pkg::PTR_W-1:0] rd_ptr;
  logic [can_rx_pkg::CNT_W-1:0] byte_cnt;

  // Record side pointers and fill level
  logic [can_rx_pkg::PTR_W-1:0] wr_info_ptr;
  logic [can_rx_pkg::PTR_W-1:0] rd_info_ptr;
  logic [can_rx_pkg::CNT_W-1:0] info_cnt;

  logic                         info_full;
  logic                         info_push;
  logic [can_rx_pkg::LEN_W-1:0] head_len;
  logic [can_rx_pkg::CNT_W-1:0] wr_step;
  logic [can_rx_pkg::CNT_W-1:0] rel_step;

  ////////////////////////////////////////////////////////////////////////////
  // Status
  ////////////////////////////////////////////////////////////////////////////

  assign data_full_o = (int'(byte_cnt) == can_rx_pkg::DATA_DEPTH);
  assign info_full   = (int'(info_cnt) == can_rx_pkg::INFO_DEPTH);

  // Close records are dropped once every slot is taken
  assign info_push = frame_close_i.valid & ~info_full;

  assign head_len = len_mem[rd_info_ptr];

  // Per-cycle count changes, zero extended to count width
  assign wr_step  = {{(can_rx_pkg::CNT_W-1){1'b0}}, byte_wr_i.valid};
  assign rel_step = release_take_i ?
                    {{(can_rx_pkg::CNT_W-can_rx_pkg::LEN_W){1'b0}}, head_len} : '0;

  ////////////////////////////////////////////////////////////////////////////
  // Byte memory
  ////////////////////////////////////////////////////////////////////////////

  // Valid writes come pre-checked by the frame writer
  always_ff @(posedge clk)
  begin
    if (byte_wr_i.valid)
      data_mem[wr_ptr] <= byte_wr_i.data;
  end

  // Window reads are asynchronous
  assign rd_data_o = data_mem[rd_addr_i];

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      byte_cnt <= '0;
    end
    else if (reset_mode_i)
    begin
      // Flush by pulling the write side back onto the read side
      wr_ptr   <= rd_ptr;
      byte_cnt <= '0;
    end
    else
    begin
      if (byte_wr_i.valid)
        wr_ptr <= wr_ptr + 1'b1;
      // Skip over the whole released frame
      if (release_take_i)
        rd_ptr <= rd_ptr + {{(can_rx_pkg::PTR_W-can_rx_pkg::LEN_W){1'b0}}, head_len};
      // Write and release in the same cycle both count
      byte_cnt <= byte_cnt + wr_step - rel_step;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Frame record memories
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (info_push)
    begin
      len_mem[wr_info_ptr] <= frame_close_i.len;
      ovr_mem[wr_info_ptr] <= frame_close_i.overrun;
    end
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      wr_info_ptr <= '0;
      rd_info_ptr <= '0;
      info_cnt    <= '0;
    end
    else if (reset_mode_i)
    begin
      wr_info_ptr <= rd_info_ptr;
      info_cnt    <= '0;
    end
    else
    begin
      if (info_push)
        wr_info_ptr <= wr_info_ptr + 1'b1;
      if (release_take_i)
        rd_info_ptr <= rd_info_ptr + 1'b1;
      // Push and pop together leave the level unchanged
      if (info_push && !release_take_i)
        info_cnt <= info_cnt + 1'b1;
      else if (!info_push && release_take_i)
        info_cnt <= info_cnt - 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////////////////////////////////////////

  assign head_o.len     = head_len;
  assign head_o.overrun = ovr_mem[rd_info_ptr];
  assign head_o.present = (info_cnt != '0);

  assign rd_ptr_o   = rd_ptr;
  assign info_cnt_o = info_cnt;

  // Fill levels stay within the memories
  a_byte_cnt_max: assert property (
    @(posedge clk) disable iff (rst) int'(byte_cnt) <= can_rx_pkg::DATA_DEPTH);
  a_info_cnt_max: assert property (
    @(posedge clk) disable iff (rst) int'(info_cnt) <= can_rx_pkg::INFO_DEPTH);

endmodule

`default_nettype wire

// ==== source/can_rx_host_window.sv ====
// CAN receive host window
`timescale 1ns/1ps
`default_nettype none

module can_rx_host_window (
  input  logic [can_rx_pkg::PTR_W-1:0]         rd_ptr_i,
  input  can_rx_pkg::head_info_t               head_i,
  input  logic                                 release_i,
  input  logic                                 extended_mode_i,
  input  logic [can_rx_pkg::PTR_W-1:0]         addr_i,
  output logic [can_rx_pkg::PTR_W-1:0]         rd_addr_o,
  output logic                                 release_take_o,
  output logic                                 overrun_o,
  output logic                                 info_empty_o
);

  // Window start for the current mode
  logic [can_rx_pkg::PTR_W-1:0] base;
  // Host offset inside the window
  logic [can_rx_pkg::PTR_W-1:0] offset;

  ////////////////////////////////////////////////////////////////////////////
  // Address mapping
  ////////////////////////////////////////////////////////////////////////////

  assign base = extended_mode_i ? can_rx_pkg::EXT_WINDOW_BASE
                                : can_rx_pkg::STD_WINDOW_BASE;

  // Both steps wrap modulo the memory size
  assign offset    = addr_i - base;
  assign rd_addr_o = rd_ptr_i + offset;

  ////////////////////////////////////////////////////////////////////////////
  // Release and status
  ////////////////////////////////////////////////////////////////////////////

  // Releases on an empty buffer are ignored here
  assign release_take_o = release_i & head_i.present;

  // Head overrun only means something while a frame is queued
  assign overrun_o    = head_i.overrun & head_i.present;
  assign info_empty_o = ~head_i.present;

endmodule

`default_nettype wire

// ==== source/can_rx_fifo.sv ====
// CAN receive buffer top
`timescale 1ns/1ps
`default_nettype none

module can_rx_fifo (
  input  logic                                 clk,
  input  logic                                 rst,
  // Frame source
  input  logic                                 wr_i,
  input  logic [7:0]                           data_i,
  // Host control
  input  logic                                 reset_mode_i,
  input  logic                                 release_i,
  input  logic                                 extended_mode_i,
  input  logic [can_rx_pkg::PTR_W-1:0]         addr_i,
  // Host read side
  output logic [7:0]                           data_o,
  output logic                                 overrun_o,
  output logic                                 info_empty_o,
  output logic [can_rx_pkg::CNT_W-1:0]         info_cnt_o
);

  can_rx_pkg::byte_wr_t         byte_wr;
  can_rx_pkg::frame_info_t      frame_close;
  can_rx_pkg::head_info_t       head;
  logic                         data_full;
  logic                         release_take;
  logic [can_rx_pkg::PTR_W-1:0] rd_ptr;
  logic [can_rx_pkg::PTR_W-1:0] rd_addr;
  logic [7:0]                   rd_data;

  // Producer side
  can_rx_frame_writer u_writer (
    .clk           (clk),
    .rst           (rst),
    .reset_mode_i  (reset_mode_i),
    .wr_i          (wr_i),
    .data_i        (data_i),
    .data_full_i   (data_full),
    .byte_wr_o     (byte_wr),
    .frame_close_o (frame_close)
  );

  // Memories and occupancy
  can_rx_buffer_store u_store (
    .clk            (clk),
    .rst            (rst),
    .reset_mode_i   (reset_mode_i),
    .byte_wr_i      (byte_wr),
    .frame_close_i  (frame_close),
    .release_take_i (release_take),
    .rd_addr_i      (rd_addr),
    .rd_data_o      (rd_data),
    .rd_ptr_o       (rd_ptr),
    .data_full_o    (data_full),
    .head_o         (head),
    .info_cnt_o     (info_cnt_o)
  );

  // Consumer side
  can_rx_host_window u_window (
    .rd_ptr_i        (rd_ptr),
    .head_i          (head),
    .release_i       (release_i),
    .extended_mode_i (extended_mode_i),
    .addr_i          (addr_i),
    .rd_addr_o       (rd_addr),
    .release_take_o  (release_take),
    .overrun_o       (overrun_o),
    .info_empty_o    (info_empty_o)
  );

  assign data_o = rd_data;

endmodule

`default_nettype wire

// ==== sim/can_rx_fifo_checker.sv ====
// CAN receive buffer result checker
`timescale 1ns/1ps
`default_nettype none

module can_rx_fifo_checker (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic [7:0]                           data_i,
  input  logic                                 overrun_i,
  input  logic                                 info_empty_i,
  input  logic [can_rx_pkg::CNT_W-1:0]         info_cnt_i,
  output int                                   err_cnt_o
);

  // Steps compared so far, and those that failed
  int test_cnt;
  int fail_cnt;

  initial
  begin
    test_cnt  = 0;
    fail_cnt  = 0;
    err_cnt_o = 0;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Free-running watch
  ////////////////////////////////////////////////////////////////////////////

  // Empty flag and frame count agree on every cycle
  always @(negedge clk)
  begin
    if (!rst && (info_empty_i !== (info_cnt_i == '0)))
    begin
      $display("info_empty_o disagrees with info_cnt_o, count is %0d", info_cnt_i);
      err_cnt_o = err_cnt_o + 1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Per-step comparison
  ////////////////////////////////////////////////////////////////////////////

  task automatic compare_step(
    input string                        name,
    input logic                         chk_data,
    input logic [7:0]                   exp_data,
    input logic                         exp_ovr,
    input logic [can_rx_pkg::CNT_W-1:0] exp_cnt
  );
    logic  exp_empty;
    logic  good;
    string exp_txt;
    string act_txt;
    // Empty is implied by a zero count
    exp_empty = (exp_cnt == '0);
    good = (info_cnt_i === exp_cnt) && (overrun_i === exp_ovr) &&
           (info_empty_i === exp_empty);
    if (chk_data && (data_i !== exp_data))
      good = 1'b0;
    // Data is only meaningful on window reads
    exp_txt = chk_data ? $sformatf("%02h", exp_data) : "--";
    act_txt = $sformatf("data %02h ovr %0b cnt %0d empty %0b",
                        data_i, overrun_i, info_cnt_i, info_empty_i);
    test_cnt = test_cnt + 1;
    if (good)
      $display("ok       %s", name);
    else
    begin
      $display("mismatch %s: expected data %s ovr %0b cnt %0d empty %0b, actual %s",
               name, exp_txt, exp_ovr, exp_cnt, exp_empty, act_txt);
      fail_cnt  = fail_cnt + 1;
      err_cnt_o = err_cnt_o + 1;
    end
  endtask

  // Closing tally
  task automatic report_counts();
    $display("Tests run %0d, failed %0d, errors in all %0d", test_cnt, fail_cnt, err_cnt_o);
  endtask

endmodule

`default_nettype wire

// ==== sim/can_rx_fifo_tb.sv ====
// CAN receive buffer testbench
`timescale 1ns/1ps
`default_nettype none

module can_rx_fifo_tb;

  localparam int          CLK_PERIOD      = 8;
  // Longest step is a 15-byte frame plus the close delay
  localparam int          MAX_STEP_CYCLES = 20;
  localparam int          MARGIN_NS       = 200;
  localparam logic [31:0] SEED            = 32'hdf27b1f1;

  // Step kinds
  localparam logic [2:0] K_CHECK   = 3'd0;
  localparam logic [2:0] K_WRITE   = 3'd1;
  localparam logic [2:0] K_READ    = 3'd2;
  localparam logic [2:0] K_RELEASE = 3'd3;
  localparam logic [2:0] K_FLUSH   = 3'd4;

  // One table row, stimulus then expectation
  typedef struct packed {
    logic [2:0] kind;
    logic [3:0] frame;
    logic [3:0] nbytes;
    logic       ext;
    logic [5:0] addr;
    logic [3:0] idx;
    logic       chk_data;
    logic       exp_ovr;
    logic [6:0] exp_cnt;
  } step_t;

  logic                         clk;
  logic                         rst;
  logic                         wr_i;
  logic [7:0]                   data_i;
  logic                         reset_mode_i;
  logic                         release_i;
  logic                         extended_mode_i;
  logic [can_rx_pkg::PTR_W-1:0] addr_i;
  logic [7:0]                   data_o;
  logic                         overrun_o;
  logic                         info_empty_o;
  logic [can_rx_pkg::CNT_W-1:0] info_cnt_o;

  int         err_cnt;
  logic       table_ready;
  step_t      steps [$];
  string      names [$];
  // Random payload, one row per frame
  logic [7:0] frame_bytes [16][16];

  can_rx_fifo DUT (
    .clk             (clk),
    .rst             (rst),
    .wr_i            (wr_i),
    .data_i          (data_i),
    .reset_mode_i    (reset_mode_i),
    .release_i       (release_i),
    .extended_mode_i (extended_mode_i),
    .addr_i          (addr_i),
    .data_o          (data_o),
    .overrun_o       (overrun_o),
    .info_empty_o    (info_empty_o),
    .info_cnt_o      (info_cnt_o)
  );

  can_rx_fifo_checker u_check (
    .clk          (clk),
    .rst          (rst),
    .data_i       (data_o),
    .overrun_i    (overrun_o),
    .info_empty_i (info_empty_o),
    .info_cnt_i   (info_cnt_o),
    .err_cnt_o    (err_cnt)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // Table
  ////////////////////////////////////////////////////////////////////////////

  task automatic fill_bytes();
    for (int f = 0; f < 16; f++)
      for (int i = 0; i < 16; i++)
        frame_bytes[f][i] = 8'($urandom);
  endtask

  task automatic push_row(input string name, input logic [2:0] kind, input int frame,
                          input int nbytes, input logic ext, input int addr, input int idx,
                          input logic chk, input logic ovr, input int cnt);
    step_t r;
    r.kind     = kind;
    r.frame    = 4'(frame);
    r.nbytes   = 4'(nbytes);
    r.ext      = ext;
    r.addr     = 6'(addr);
    r.idx      = 4'(idx);
    r.chk_data = chk;
    r.exp_ovr  = ovr;
    r.exp_cnt  = 7'(cnt);
    steps.push_back(r);
    names.push_back(name);
  endtask

  task automatic build_table();
    //       name               kind       frm len ext   addr idx chk   ovr   cnt
    push_row("reset_empty",     K_CHECK,   0,  0,  1'b1, 0,   0,  1'b0, 1'b0, 0);
    push_row("single_write",    K_WRITE,   0,  8,  1'b1, 0,   0,  1'b0, 1'b0, 1);
    for (int i = 0; i < 8; i++)
      push_row($sformatf("ext_rd_%0d", i), K_READ, 0, 0, 1'b1, 16 + i, i, 1'b1, 1'b0, 1);
    for (int i = 0; i < 8; i++)
      push_row($sformatf("std_rd_%0d", i), K_READ, 0, 0, 1'b0, 20 + i, i, 1'b1, 1'b0, 1);
    push_row("single_release",  K_RELEASE, 0,  0,  1'b1, 0,   0,  1'b0, 1'b0, 0);
    // Three frames queued, drained one by one
    push_row("queue_write_a",   K_WRITE,   1,  5,  1'b1, 0,   0,  1'b0, 1'b0, 1);
    push_row("queue_write_b",   K_WRITE,   2,  13, 1'b1, 0,   0,  1'b0, 1'b0, 2);
    push_row("queue_write_c",   K_WRITE,   3,  7,  1'b1, 0,   0,  1'b0, 1'b0, 3);
    push_row("queue_head_a",    K_READ,    1,  0,  1'b1, 16,  0,  1'b1, 1'b0, 3);
    push_row("queue_release_a", K_RELEASE, 0,  0,  1'b1, 0,   0,  1'b0, 1'b0, 2);
    push_row("queue_head_b",    K_READ,    2,  0,  1'b1, 16,  0,  1'b1, 1'b0, 2);
    push_row("queue_tail_b",    K_READ,    2,  0,  1'b1, 28,  12, 1'b1, 1'b0, 2);
    push_row("queue_release_b", K_RELEASE, 0,  0,  1'b1, 0,   0,  1'b0, 1'b0, 1);
    push_row("queue_head_c",    K_READ,    3,  0,  1'b0, 20,  0,  1'b1, 1'b0, 1);
    push_row("queue_release_c", K_RELEASE, 0,  0,  1'b1, 0,   0,  1'b0, 1'b0, 0);
    push_row("empty_release",   K_RELEASE, 0,  0,  1'b1, 0,   0,  1'b0, 1'b0, 0);
    // Four 15-byte frames leave room for 4 bytes of the next one
    for (int f = 4; f < 8; f++)
      push_row($sformatf("fill_write_%0d", f), K_WRITE, f, 15, 1'b1, 0, 0, 1'b0, 1'b0, f - 3);
    push_row("overrun_write",   K_WRITE,   8,  8,  1'b1, 0,   0,  1'b0, 1'b0, 5);
    push_row("fill_head_4",     K_READ,    4,  0,  1'b1, 16,  0,  1'b1, 1'b0, 5);
    for (int f = 5; f < 8; f++)
    begin
      push_row($sformatf("fill_release_%0d", f), K_RELEASE, 0, 0, 1'b1, 0, 0, 1'b0, 1'b0, 9 - f);
      push_row($sformatf("fill_head_%0d", f), K_READ, f, 0, 1'b1, 16, 0, 1'b1, 1'b0, 9 - f);
    end
    push_row("overrun_release", K_RELEASE, 0,  0,  1'b1, 0,   0,  1'b0, 1'b1, 1);
    for (int i = 0; i < 4; i++)
      push_row($sformatf("overrun_rd_%0d", i), K_READ, 8, 0, 1'b1, 16 + i, i, 1'b1, 1'b1, 1);
    push_row("overrun_drop",    K_RELEASE, 0,  0,  1'b1, 0,   0,  1'b0, 1'b0, 0);
    push_row("later_write",     K_WRITE,   9,  6,  1'b1, 0,   0,  1'b0, 1'b0, 1);
    push_row("later_rd",        K_READ,    9,  0,  1'b1, 16,  0,  1'b1, 1'b0, 1);
    // Reset mode drops everything queued
    push_row("flush_write_a",   K_WRITE,   10, 9,  1'b1, 0,   0,  1'b0, 1'b0, 2);
    push_row("flush_write_b",   K_WRITE,   11, 4,  1'b1, 0,   0,  1'b0, 1'b0, 3);
    push_row("flush",           K_FLUSH,   0,  0,  1'b1, 0,   0,  1'b0, 1'b0, 0);
    push_row("after_flush",     K_WRITE,   12, 10, 1'b1, 0,   0,  1'b0, 1'b0, 1);
    for (int i = 0; i < 10; i++)
      push_row($sformatf("after_flush_rd_%0d", i), K_READ, 12, 0, 1'b0, 20 + i, i,
               1'b1, 1'b0, 1);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Drivers, all called at a falling edge
  ////////////////////////////////////////////////////////////////////////////

  // Record lands one edge after the strobe is seen low
  task automatic send_frame(input int f, input int n);
    for (int i = 0; i < n; i++)
    begin
      wr_i   = 1'b1;
      data_i = frame_bytes[f][i];
      @(negedge clk);
    end
    wr_i   = 1'b0;
    data_i = '0;
    repeat (2) @(negedge clk);
  endtask

  task automatic pulse_release();
    release_i = 1'b1;
    @(negedge clk);
    release_i = 1'b0;
  endtask

  task automatic pulse_flush();
    reset_mode_i = 1'b1;
    @(negedge clk);
    reset_mode_i = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Run
  ////////////////////////////////////////////////////////////////////////////

  initial
  begin
    step_t st;
    clk             = 1'b0;
    rst             = 1'b1;
    wr_i            = 1'b0;
    data_i          = '0;
    reset_mode_i    = 1'b0;
    release_i       = 1'b0;
    extended_mode_i = 1'b1;
    addr_i          = '0;
    table_ready     = 1'b0;
    void'($urandom(SEED));
    fill_bytes();
    build_table();
    table_ready = 1'b1;
    repeat (2) @(negedge clk);
    rst = 1'b0;
    for (int s = 0; s < steps.size(); s++)
    begin
      st = steps[s];
      case (st.kind)
        K_WRITE:   send_frame(int'(st.frame), int'(st.nbytes));
        K_RELEASE: pulse_release();
        K_FLUSH:   pulse_flush();
        K_READ:
        begin
          extended_mode_i = st.ext;
          addr_i          = st.addr;
          @(negedge clk);
        end
        default:   @(negedge clk);
      endcase
      u_check.compare_step(names[s], st.chk_data, frame_bytes[st.frame][st.idx],
                           st.exp_ovr, st.exp_cnt);
    end
    u_check.report_counts();
    if (err_cnt == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

  // Watchdog sized from the table length
  initial
  begin
    wait (table_ready);
    #(steps.size() * MAX_STEP_CYCLES * CLK_PERIOD + MARGIN_NS);
    $display("timeout: the stimulus table did not finish in time");
    $display("Done: errors found");
    $finish;
  end

endmodule

`default_nettype wire

// ==== can_rx_fifo.f ====
source/can_rx_pkg.sv
source/can_rx_frame_writer.sv
source/can_rx_buffer_store.sv
source/can_rx_host_window.sv
source/can_rx_fifo.sv
sim/can_rx_fifo_checker.sv
sim/can_rx_fifo_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the CAN receive buffer testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -f can_rx_fifo.f \
  --top-module can_rx_fifo_tb -Mdir "$BUILD_DIR" -o can_rx_fifo_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/can_rx_fifo_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Done: errors found" "$LOG"; then
  exit 1
fi
exit 0
